// File: compile.f
+incdir+include
design/backend_pkg.sv
design/instr_queue.sv
design/decode_stage.sv
design/int_reg_file.sv
design/execute_stage.sv
design/commit_stage.sv
design/backend.sv
testbench/tb_backend.sv

// File: design/backend.sv
// back-end top level connecting queue, decode, register file, execute and commit
`default_nettype none

module backend (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // front end, credit based
  input  logic                 instr_valid_i,
  input  backend_pkg::instr_t  instr_i,
  output logic                 credit_return_o,
  // retire port, no back-pressure
  output logic                 retire_valid_o,
  output backend_pkg::retire_t retire_o
);

  import backend_pkg::*;

  // queue to decode
  logic      q_head_valid;
  instr_t    q_head_instr;

  // decode and register file
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  xlen_t     rs1_value;
  xlen_t     rs2_value;

  // decode to execute
  logic      issue_valid;
  issue_op_t issue_op;

  // execute to commit
  logic      exec_valid;
  retire_t   exec_result;

  // commit feedback
  logic      wb_valid;
  reg_idx_t  wb_rd;
  xlen_t     wb_value;
  logic      release_valid;
  reg_idx_t  release_rd;

  // --------------------------------------------------
  // instruction queue, pop doubles as credit return
  // --------------------------------------------------
  instr_queue u_instr_queue (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (instr_valid_i),
    .push_instr_i(instr_i),
    .head_valid_o(q_head_valid),
    .head_instr_o(q_head_instr),
    .pop_i       (credit_return_o)
  );

  decode_stage u_decode_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (q_head_valid),
    .instr_i        (q_head_instr),
    .pop_o          (credit_return_o),
    .rs1_idx_o      (rs1_idx),
    .rs2_idx_o      (rs2_idx),
    .rs1_value_i    (rs1_value),
    .rs2_value_i    (rs2_value),
    .release_valid_i(release_valid),
    .release_rd_i   (release_rd),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op)
  );

  int_reg_file u_int_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_value_o(rs1_value),
    .rs2_value_o(rs2_value),
    .wb_valid_i (wb_valid),
    .wb_rd_i    (wb_rd),
    .wb_value_i (wb_value)
  );

  // --------------------------------------------------
  // execute and commit
  // --------------------------------------------------
  execute_stage u_execute_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .issue_valid_i(issue_valid),
    .issue_op_i   (issue_op),
    .exec_valid_o (exec_valid),
    .exec_result_o(exec_result)
  );

  commit_stage u_commit_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .exec_valid_i   (exec_valid),
    .exec_result_i  (exec_result),
    .wb_valid_o     (wb_valid),
    .wb_rd_o        (wb_rd),
    .wb_value_o     (wb_value),
    .release_valid_o(release_valid),
    .release_rd_o   (release_rd),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

`default_nettype wire

// File: design/backend_pkg.sv
// shared widths, encodings, ALU codes and stage structs; imported by every back-end module
`default_nettype none

package backend_pkg;

  // --------------------------------------------------
  // widths and sizes
  // --------------------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned NUM_REGS    = 32;
  localparam int unsigned QUEUE_DEPTH = 4;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;
  // counts zero up to QUEUE_DEPTH inclusive
  typedef logic [2:0]      credit_cnt_t;

  // --------------------------------------------------
  // RV32I encodings
  // --------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLT = 3'b010;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

  // --------------------------------------------------
  // ALU operation codes
  // --------------------------------------------------
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLT = 3'd5;

  // --------------------------------------------------
  // stage payloads
  // --------------------------------------------------
  // decode to execute
  typedef struct packed {
    alu_op_t  alu_op;
    reg_idx_t rd;
    xlen_t    operand_a;
    // rs2 value or sign-extended immediate
    xlen_t    operand_b;
    logic     illegal;
  } issue_op_t;

  // execute to commit, and the retire port
  typedef struct packed {
    reg_idx_t rd;
    xlen_t    value;
    logic     illegal;
  } retire_t;

endpackage

`default_nettype wire

// File: design/commit_stage.sv
// retire register; writes back and frees the busy bit on the edge that loads the retire port
`default_nettype none

module commit_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // from execute
  input  logic                  exec_valid_i,
  input  backend_pkg::retire_t  exec_result_i,
  // register file write
  output logic                  wb_valid_o,
  output backend_pkg::reg_idx_t wb_rd_o,
  output backend_pkg::xlen_t    wb_value_o,
  // busy table release
  output logic                  release_valid_o,
  output backend_pkg::reg_idx_t release_rd_o,
  // retire port
  output logic                  retire_valid_o,
  output backend_pkg::retire_t  retire_o
);

  // --------------------------------------------------
  // write back and release
  // --------------------------------------------------
  // legal results with nonzero rd only
  assign wb_valid_o = exec_valid_i && !exec_result_i.illegal && (exec_result_i.rd != '0);
  assign wb_rd_o    = exec_result_i.rd;
  assign wb_value_o = exec_result_i.value;

  // same register freed at the same edge as the write
  assign release_valid_o = wb_valid_o;
  assign release_rd_o    = exec_result_i.rd;

  // --------------------------------------------------
  // retire register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      // every op retires, illegal or not
      retire_valid_o <= exec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_valid_i) begin
      retire_o <= exec_result_i;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// decodes the queue head, checks the busy table and issues one ALU op per cycle to execute
`default_nettype none

module decode_stage (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // instruction queue
  input  logic                   instr_valid_i,
  input  backend_pkg::instr_t    instr_i,
  output logic                   pop_o,
  // register file reads
  output backend_pkg::reg_idx_t  rs1_idx_o,
  output backend_pkg::reg_idx_t  rs2_idx_o,
  input  backend_pkg::xlen_t     rs1_value_i,
  input  backend_pkg::xlen_t     rs2_value_i,
  // busy release from commit
  input  logic                   release_valid_i,
  input  backend_pkg::reg_idx_t  release_rd_i,
  // issue to execute
  output logic                   issue_valid_o,
  output backend_pkg::issue_op_t issue_op_o
);

  import backend_pkg::*;

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  reg_idx_t      rd_idx;
  xlen_t         imm;
  alu_op_t       alu_op;
  logic          illegal;
  logic          use_rs1;
  logic          use_rs2;
  logic          use_imm;
  logic          hazard;
  logic          writes_rd;
  // one bit per register, set while a write is in flight
  logic [NUM_REGS-1:0] busy_q;

  // --------------------------------------------------
  // field split
  // --------------------------------------------------
  assign opcode    = instr_i[6:0];
  assign rd_idx    = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign rs1_idx_o = instr_i[19:15];
  assign rs2_idx_o = instr_i[24:20];
  assign funct7    = instr_i[31:25];
  // I-type immediate, sign extended
  assign imm       = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

  // --------------------------------------------------
  // opcode and function decode
  // --------------------------------------------------
  always_comb begin
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          FUNCT3_ADD: alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
          FUNCT3_SLT: alu_op = ALU_SLT;
          FUNCT3_XOR: alu_op = ALU_XOR;
          FUNCT3_OR:  alu_op = ALU_OR;
          FUNCT3_AND: alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
        // only SUB may use the alternate funct7
        if (funct7 != FUNCT7_BASE && !(funct7 == FUNCT7_SUB && funct3 == FUNCT3_ADD)) begin
          illegal = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        // ADDI only
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        illegal = (funct3 != FUNCT3_ADD);
      end
      default: illegal = 1'b1;
    endcase
    // illegal encodings wait on nothing
    if (illegal) begin
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  // --------------------------------------------------
  // scoreboard check and issue
  // --------------------------------------------------
  assign hazard    = (use_rs1 && busy_q[rs1_idx_o]) || (use_rs2 && busy_q[rs2_idx_o]);
  assign writes_rd = !illegal && (rd_idx != '0);

  // pop and issue in the same cycle
  assign pop_o         = instr_valid_i && !hazard;
  assign issue_valid_o = pop_o;

  assign issue_op_o = '{
    alu_op:    alu_op,
    rd:        rd_idx,
    operand_a: rs1_value_i,
    operand_b: use_imm ? imm : rs2_value_i,
    illegal:   illegal
  };

  // busy table update
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= '0;
    end else begin
      if (release_valid_i) begin
        busy_q[release_rd_i] <= 1'b0;
      end
      // new issue overrides an older release of the same rd
      if (pop_o && writes_rd) begin
        busy_q[rd_idx] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// single-cycle ALU stage; registers the result of each issued op for commit
`default_nettype none

module execute_stage (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   issue_valid_i,
  input  backend_pkg::issue_op_t issue_op_i,
  output logic                   exec_valid_o,
  output backend_pkg::retire_t   exec_result_o
);

  import backend_pkg::*;

  xlen_t alu_result;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (issue_op_i.alu_op)
      ALU_ADD: alu_result = issue_op_i.operand_a + issue_op_i.operand_b;
      ALU_SUB: alu_result = issue_op_i.operand_a - issue_op_i.operand_b;
      ALU_AND: alu_result = issue_op_i.operand_a & issue_op_i.operand_b;
      ALU_OR:  alu_result = issue_op_i.operand_a | issue_op_i.operand_b;
      ALU_XOR: alu_result = issue_op_i.operand_a ^ issue_op_i.operand_b;
      // signed compare, result is 0 or 1
      ALU_SLT: alu_result = {{(XLEN-1){1'b0}},
                             $signed(issue_op_i.operand_a) < $signed(issue_op_i.operand_b)};
      default: alu_result = '0;
    endcase
    // illegal ops report a zero value
    if (issue_op_i.illegal) begin
      alu_result = '0;
    end
  end

  // valid bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exec_valid_o <= 1'b0;
    end else begin
      exec_valid_o <= issue_valid_i;
    end
  end

  // result payload, rd and illegal pass through
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      exec_result_o <= '{rd: issue_op_i.rd, value: alu_result, illegal: issue_op_i.illegal};
    end
  end

endmodule

`default_nettype wire

// File: design/instr_queue.sv
// four-entry instruction FIFO between the front end and decode; each pop frees one credit
`default_nettype none

module instr_queue (
  input  logic                clk_i,
  input  logic                reset_i,
  // front end side
  input  logic                push_i,
  input  backend_pkg::instr_t push_instr_i,
  // decode side
  output logic                head_valid_o,
  output backend_pkg::instr_t head_instr_o,
  input  logic                pop_i
);

  import backend_pkg::*;

  // storage, no reset needed
  instr_t mem_q [QUEUE_DEPTH];

  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr_q;
  credit_cnt_t                    count_q;

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap naturally, depth is a power of two
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        // push and pop together, occupancy unchanged
        default: count_q <= count_q;
      endcase
    end
  end

  // write port, room guaranteed by credits
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_instr_i;
    end
  end

  // head visible the cycle after its push
  assign head_valid_o = (count_q != '0);
  assign head_instr_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: design/int_reg_file.sv
// integer register file, two combinational reads and one write port, x0 tied to zero
`default_nettype none

module int_reg_file (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // read ports for decode
  input  backend_pkg::reg_idx_t rs1_idx_i,
  input  backend_pkg::reg_idx_t rs2_idx_i,
  output backend_pkg::xlen_t    rs1_value_o,
  output backend_pkg::xlen_t    rs2_value_o,
  // write port from commit
  input  logic                  wb_valid_i,
  input  backend_pkg::reg_idx_t wb_rd_i,
  input  backend_pkg::xlen_t    wb_value_i
);

  import backend_pkg::*;

  xlen_t regs_q [NUM_REGS];

  // all registers start at zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_valid_i && (wb_rd_i != '0)) begin
      // x0 never written
      regs_q[wb_rd_i] <= wb_value_i;
    end
  end

  // no write bypass, busy table holds readers until the write lands
  assign rs1_value_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_value_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

// File: include/backend_tb_model.svh
// reference model for the testbench top; include inside the module to get model_retire
`ifndef BACKEND_TB_MODEL_SVH
`define BACKEND_TB_MODEL_SVH

// architectural state of the model, x0 stays zero
backend_pkg::xlen_t model_regs [backend_pkg::NUM_REGS] = '{default: '0};

// applies one instruction, returns the expected retire record
function automatic backend_pkg::retire_t model_retire(input backend_pkg::instr_t instr);
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  backend_pkg::reg_idx_t rd;
  backend_pkg::xlen_t    a;
  backend_pkg::xlen_t    b;
  backend_pkg::xlen_t    value;
  logic                  illegal;
  opcode  = instr[6:0];
  rd      = instr[11:7];
  funct3  = instr[14:12];
  funct7  = instr[31:25];
  a       = model_regs[instr[19:15]];
  b       = model_regs[instr[24:20]];
  value   = '0;
  illegal = 1'b0;
  if (opcode == backend_pkg::OPCODE_OP_IMM && funct3 == backend_pkg::FUNCT3_ADD) begin
    value = a + {{20{instr[31]}}, instr[31:20]};
  end else if (opcode == backend_pkg::OPCODE_OP && funct7 == backend_pkg::FUNCT7_SUB &&
               funct3 == backend_pkg::FUNCT3_ADD) begin
    value = a - b;
  end else if (opcode == backend_pkg::OPCODE_OP && funct7 == backend_pkg::FUNCT7_BASE) begin
    case (funct3)
      backend_pkg::FUNCT3_ADD: value = a + b;
      backend_pkg::FUNCT3_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      backend_pkg::FUNCT3_XOR: value = a ^ b;
      backend_pkg::FUNCT3_OR:  value = a | b;
      backend_pkg::FUNCT3_AND: value = a & b;
      default:                 illegal = 1'b1;
    endcase
  end else begin
    illegal = 1'b1;
  end
  // illegal ops report zero and write nothing
  if (illegal) begin
    value = '0;
  end else if (rd != '0) begin
    model_regs[rd] = value;
  end
  return '{rd: rd, value: value, illegal: illegal};
endfunction

`endif

// File: testbench/tb_backend.sv
// testbench for the back end; sends random credit-limited traffic and checks every retirement
`default_nettype none

module tb_backend;

  timeunit 1ns;
  timeprecision 1ps;

  import backend_pkg::*;

  localparam int          NUM_TESTS   = 300;
  localparam int unsigned SEED        = 32'hac47;
  localparam int          CYCLE_LIMIT = NUM_TESTS * 20 + 100;
  localparam int          DRAIN       = 10;

  logic    clk;
  logic    reset;
  logic    instr_valid;
  instr_t  instr;
  logic    credit_return;
  logic    retire_valid;
  retire_t retire_rec;

  // sent words in send order
  instr_t  sent_q [$];
  int      retired_count;
  int      cycle_count;

  `include "backend_tb_model.svh"

  backend dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .credit_return_o(credit_return),
    .retire_valid_o (retire_valid),
    .retire_o       (retire_rec)
  );

  // --------------------------------------------------
  // error reporting and compare tasks
  // --------------------------------------------------
  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      report_error($sformatf(
        "MISMATCH retire_o: got rd=%h value=%h illegal=%h, expected rd=%h value=%h illegal=%h",
        got.rd, got.value, got.illegal, exp.rd, exp.value, exp.illegal));
    end
  endtask

  task automatic check_credits(input credit_cnt_t got, input credit_cnt_t exp);
    if (got !== exp) begin
      report_error($sformatf("MISMATCH credit count: got %h expected %h", got, exp));
    end
  endtask

  // registers from a small set so hazards show up often
  function automatic instr_t random_instr();
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    int unsigned kind;
    rd   = reg_idx_t'($urandom_range(3));
    rs1  = reg_idx_t'($urandom_range(3));
    rs2  = reg_idx_t'($urandom_range(3));
    imm  = 12'($urandom);
    kind = $urandom_range(9);
    case (kind)
      0:       return {FUNCT7_BASE, rs2, rs1, FUNCT3_ADD, rd, OPCODE_OP};
      1:       return {FUNCT7_SUB, rs2, rs1, FUNCT3_ADD, rd, OPCODE_OP};
      2:       return {FUNCT7_BASE, rs2, rs1, FUNCT3_AND, rd, OPCODE_OP};
      3:       return {FUNCT7_BASE, rs2, rs1, FUNCT3_OR, rd, OPCODE_OP};
      4:       return {FUNCT7_BASE, rs2, rs1, FUNCT3_XOR, rd, OPCODE_OP};
      5:       return {FUNCT7_BASE, rs2, rs1, FUNCT3_SLT, rd, OPCODE_OP};
      6, 7:    return {imm, rs1, FUNCT3_ADD, rd, OPCODE_OP_IMM};
      // shift encoding is unsupported
      8:       return {FUNCT7_BASE, rs2, rs1, 3'b001, rd, OPCODE_OP};
      // load opcode is unsupported
      default: return {imm, rs1, 3'b010, rd, 7'b0000011};
    endcase
  endfunction

  // --------------------------------------------------
  // clock, reset and timeout
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      report_error("timeout, retirements stopped before all instructions came back");
    end
  end

  // --------------------------------------------------
  // stimulus with credit tracking
  // --------------------------------------------------
  initial begin : stimulus
    int     credits;
    int     sent;
    instr_t word;
    reset         = 1'b1;
    instr_valid   = 1'b0;
    instr         = '0;
    retired_count = 0;
    cycle_count   = 0;
    credits       = QUEUE_DEPTH;
    sent          = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (sent < NUM_TESTS || retired_count < NUM_TESTS) begin
      @(posedge clk);
      if (credit_return) begin
        credits++;
      end
      if (credits > QUEUE_DEPTH) begin
        report_error("surplus credit_return_o pulse, credit count above queue depth");
      end
      // send only while a credit is held and leave random gaps
      if (sent < NUM_TESTS && credits > 0 && $urandom_range(3) != 0) begin
        word = random_instr();
        instr_valid <= 1'b1;
        instr       <= word;
        sent_q.push_back(word);
        credits--;
        sent++;
      end else begin
        instr_valid <= 1'b0;
      end
    end
    // drain until every credit is back
    repeat (DRAIN) begin
      @(posedge clk);
      if (credit_return) begin
        credits++;
      end
      if (credits > QUEUE_DEPTH) begin
        report_error("surplus credit_return_o pulse, credit count above queue depth");
      end
    end
    check_credits(credit_cnt_t'(credits), credit_cnt_t'(QUEUE_DEPTH));
    $display("Test passed");
    $finish;
  end

  // --------------------------------------------------
  // compare process in program order
  // --------------------------------------------------
  always @(posedge clk) begin : compare
    retire_t exp_rec;
    if (!reset && retire_valid) begin
      if (sent_q.size() == 0) begin
        report_error("retirement seen with no instruction outstanding");
      end else begin
        exp_rec = model_retire(sent_q.pop_front());
        check_retire(retire_rec, exp_rec);
        retired_count++;
      end
    end
  end

endmodule

`default_nettype wire
